// File: src/isaPkg.sv
// Instruction set definitions for the execution back end
// Holds the opcode and function code encodings and the two micro-op
// formats, overlaid in one packed union so a word can be read either way

package isaPkg;

	// Width of one micro-op word
	localparam int UOP_W = 32;

	// ==============================
	// Opcodes and function codes
	// ==============================

	// Major opcodes, only the ones the divide path cares about
	typedef enum logic [6:0] {
		OP_ADD  = 7'h04,
		OP_ORI  = 7'h09,
		OP_DIVI = 7'h13,
		OP_R3B  = 7'h20,
		OP_R3W  = 7'h21,
		OP_R3T  = 7'h22
	} opcode_t;

	// Function codes of the register-form ALU ops
	typedef enum logic [5:0] {
		FN_ADD  = 6'h04,
		FN_DIV  = 6'h10,
		FN_DIVU = 6'h11,
		FN_MOD  = 6'h12,
		FN_MODU = 6'h13
	} func_t;

	typedef logic [4:0] regNum_t;

	// ==============================
	// Micro-op formats
	// ==============================

	// Three-register format, opcode in the top bits
	typedef struct packed {
		opcode_t    opcode;
		regNum_t    rd;
		regNum_t    rs1;
		regNum_t    rs2;
		func_t      func;
		logic [3:0] spare;
	} r3Fmt_t;

	// Immediate format, the low 15 bits of the word carry a signed immediate
	typedef struct packed {
		opcode_t     opcode;
		regNum_t     rd;
		regNum_t     rs1;
		logic [14:0] imm;
	} immFmt_t;

	// Opcode, rd and rs1 sit at the same bits in both formats
	typedef union packed {
		r3Fmt_t  r3;
		immFmt_t ri;
	} microOp_t;

endpackage

// File: src/divPkg.sv
// Divider definitions
// Operand widths, size codes, iteration counts, control states and the
// size extension shared by the operand and result stages

package divPkg;

	// Operand and result width
	localparam int DATA_W = 32;

	// Quotient bits produced for each operand size
	localparam int ITER_BYTE  = 8;
	localparam int ITER_WYDE  = 16;
	localparam int ITER_TETRA = 32;

	// Wide enough to hold ITER_TETRA
	localparam int CNT_W = 6;

	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_WYDE  = 2'd1,
		SZ_TETRA = 2'd2
	} opSize_t;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ITER = 2'd1,
		ST_FIX  = 2'd2,
		ST_DONE = 2'd3
	} divState_t;

	// Keeps the low bits for the size and fills the rest with zeros or
	// with copies of the size's top bit
	function automatic logic [DATA_W-1:0] sizeExtend(
		input logic [DATA_W-1:0] value,
		input opSize_t           size,
		input logic              signedExt
	);
		logic fill;
		case (size)
			SZ_BYTE:
			begin
				fill = signedExt & value[ITER_BYTE-1];
				sizeExtend = {{(DATA_W-ITER_BYTE){fill}}, value[ITER_BYTE-1:0]};
			end
			SZ_WYDE:
			begin
				fill = signedExt & value[ITER_WYDE-1];
				sizeExtend = {{(DATA_W-ITER_WYDE){fill}}, value[ITER_WYDE-1:0]};
			end
			default:
			begin
				// A tetra already fills the whole word
				sizeExtend = value;
			end
		endcase
	endfunction

endpackage

// File: src/divDecode.sv
// Divide decoder
// Recognises the register and immediate divide micro-ops and pulls out
// size, signedness, quotient or remainder select and the divisor source

`timescale 1ns/10ps

module divDecode (
	input  isaPkg::microOp_t          uop,
	input  logic [divPkg::DATA_W-1:0] opB,
	output logic                      isDiv,
	output logic                      signedOp,
	output logic                      remSel,
	output logic                      useImm,
	output divPkg::opSize_t           opSize,
	output logic [divPkg::DATA_W-1:0] divisorRaw
);
	import isaPkg::*;
	import divPkg::*;

	logic              isR3;
	logic              isDivFunc;
	logic [DATA_W-1:0] immValue;

	// Register-form ALU opcodes at the three supported sizes
	assign isR3 = (uop.r3.opcode == OP_R3B) || (uop.r3.opcode == OP_R3W) ||
		(uop.r3.opcode == OP_R3T);

	// The func field only means something in the register format
	assign isDivFunc = (uop.r3.func == FN_DIV) || (uop.r3.func == FN_DIVU) ||
		(uop.r3.func == FN_MOD) || (uop.r3.func == FN_MODU);

	assign useImm = (uop.ri.opcode == OP_DIVI);
	assign isDiv  = useImm || (isR3 && isDivFunc);

	// DIVI is always a signed quotient
	assign signedOp = useImm || (uop.r3.func == FN_DIV) || (uop.r3.func == FN_MOD);
	assign remSel   = !useImm && ((uop.r3.func == FN_MOD) || (uop.r3.func == FN_MODU));

	// Size comes from the register opcode, the immediate form is tetra only
	always_comb
	begin
		case (uop.r3.opcode)
			OP_R3B:  opSize = SZ_BYTE;
			OP_R3W:  opSize = SZ_WYDE;
			default: opSize = SZ_TETRA;
		endcase
	end

	// Sign-extended 15-bit immediate
	assign immValue   = {{(DATA_W-15){uop.ri.imm[14]}}, uop.ri.imm};
	assign divisorRaw = useImm ? immValue : opB;

endmodule

// File: src/divIterCounter.sv
// Divide iteration counter
// Loaded with the quotient bit count for the operand size and counted
// down once per step, flags the step that produces the last bit

`timescale 1ns/10ps

module divIterCounter (
	input  logic            clk,
	input  logic            arstN,
	input  logic            load,
	input  logic            countEn,
	input  divPkg::opSize_t opSize,
	output logic            lastIter
);
	import divPkg::*;

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] loadValue;

	// One step per quotient bit
	always_comb
	begin
		case (opSize)
			SZ_BYTE:  loadValue = CNT_W'(ITER_BYTE);
			SZ_WYDE:  loadValue = CNT_W'(ITER_WYDE);
			default:  loadValue = CNT_W'(ITER_TETRA);
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			count <= '0;
		else if (load)
			count <= loadValue;
		else if (countEn)
			count <= count - 1'b1;
	end

	// The step taken while the count is one is the final one
	assign lastIter = (count == CNT_W'(1));

	// The controller must leave ST_ITER on the final step
	assert property (@(posedge clk) disable iff (!arstN) countEn |-> (count != '0))
		else $error("divIterCounter: step requested with the count exhausted");

endmodule

// File: src/divControl.sv
// Divider sequencer
// Accepts a divide from idle, runs the iteration steps, loads the fixed up
// result and raises done for one cycle before returning to idle

`timescale 1ns/10ps

module divControl (
	input  logic clk,
	input  logic arstN,
	input  logic issue,
	input  logic isDiv,
	input  logic lastIter,
	output logic accept,
	output logic iterEn,
	output logic fixLoad,
	output logic busy,
	output logic done
);
	import divPkg::*;

	divState_t state;
	divState_t stateNext;

	// A non-divide issue is simply not accepted
	assign accept = (state == ST_IDLE) && issue && isDiv;

	// ==============================
	// Next state
	// ==============================

	always_comb
	begin
		stateNext = state;
		case (state)
			ST_IDLE:
			begin
				if (accept)
					stateNext = ST_ITER;
			end
			ST_ITER:
			begin
				// The last quotient bit is taken on this edge
				if (lastIter)
					stateNext = ST_FIX;
			end
			ST_FIX:
				stateNext = ST_DONE;
			ST_DONE:
				stateNext = ST_IDLE;
			default:
				stateNext = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			state <= ST_IDLE;
		else
			state <= stateNext;
	end

	// Decoded state outputs
	assign iterEn  = (state == ST_ITER);
	assign fixLoad = (state == ST_FIX);
	assign done    = (state == ST_DONE);
	assign busy    = (state != ST_IDLE);

	// ==============================
	// Checks
	// ==============================

	// The issuing stage has to wait until busy falls
	assert property (@(posedge clk) disable iff (!arstN) busy |-> !issue)
		else $error("divControl: issue strobed while the divider is busy");

	// Done is a single-cycle pulse
	assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("divControl: done held for more than one cycle");

endmodule

// File: src/divOperandPrep.sv
// Divide operand preparation
// Extracts the operands at the selected size, forms their magnitudes,
// left-aligns the dividend and registers the sign and metadata flags

`timescale 1ns/10ps

module divOperandPrep (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      accept,
	input  logic                      signedOp,
	input  logic                      remSel,
	input  divPkg::opSize_t           opSize,
	input  logic [divPkg::DATA_W-1:0] opA,
	input  logic [divPkg::DATA_W-1:0] divisorRaw,
	input  isaPkg::regNum_t           rd,
	output logic [divPkg::DATA_W-1:0] absDividend,
	output logic [divPkg::DATA_W-1:0] absDivisor,
	output logic                      negQ,
	output logic                      negR,
	output logic                      remSelQ,
	output logic                      signedQ,
	output logic                      zeroDiv,
	output divPkg::opSize_t           sizeQ,
	output isaPkg::regNum_t           rdQ
);
	import divPkg::*;

	logic [DATA_W-1:0] extA;
	logic [DATA_W-1:0] extB;
	logic [DATA_W-1:0] absA;
	logic              signA;
	logic              signB;

	// Operands at the size, extended to the full width
	assign extA = sizeExtend(opA, opSize, signedOp);
	assign extB = sizeExtend(divisorRaw, opSize, signedOp);

	// After extension the top bit is the operand sign for signed ops
	assign signA = signedOp & extA[DATA_W-1];
	assign signB = signedOp & extB[DATA_W-1];

	// The most negative value maps onto its unsigned magnitude
	assign absA       = signA ? -extA : extA;
	assign absDivisor = signB ? -extB : extB;

	// Shift the dividend up so its top bit enters the datapath first
	always_comb
	begin
		case (opSize)
			SZ_BYTE:  absDividend = absA << (DATA_W - ITER_BYTE);
			SZ_WYDE:  absDividend = absA << (DATA_W - ITER_WYDE);
			default:  absDividend = absA;
		endcase
	end

	// Quotient is negative when the signs differ, remainder follows the dividend
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			negQ    <= 1'b0;
			negR    <= 1'b0;
			remSelQ <= 1'b0;
			signedQ <= 1'b0;
			zeroDiv <= 1'b0;
			sizeQ   <= SZ_TETRA;
			rdQ     <= '0;
		end
		else if (accept)
		begin
			negQ    <= signA ^ signB;
			negR    <= signA;
			remSelQ <= remSel;
			signedQ <= signedOp;
			zeroDiv <= (extB == '0);
			sizeQ   <= opSize;
			rdQ     <= rd;
		end
	end

endmodule

// File: src/divCore.sv
// Restoring divide datapath
// Shifts one dividend bit per step into a partial remainder, subtracts the
// divisor when the result stays non-negative and collects the quotient bit

`timescale 1ns/10ps

module divCore (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      load,
	input  logic                      step,
	input  logic [divPkg::DATA_W-1:0] dividend,
	input  logic [divPkg::DATA_W-1:0] divisor,
	output logic [divPkg::DATA_W-1:0] quotient,
	output logic [divPkg::DATA_W-1:0] remainder
);
	import divPkg::*;

	logic [DATA_W-1:0] partRem;
	logic [DATA_W-1:0] dividendSh;
	logic [DATA_W-1:0] divisorQ;
	logic [DATA_W:0]   shifted;
	logic [DATA_W:0]   diff;
	logic              qBit;

	// Bring in the next dividend bit and trial subtract at 33 bits
	assign shifted = {partRem, dividendSh[DATA_W-1]};
	assign diff    = shifted - {1'b0, divisorQ};

	// Partial remainder stays below the divisor, so the top diff bit is the borrow
	assign qBit = !diff[DATA_W];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			partRem    <= '0;
			dividendSh <= '0;
			divisorQ   <= '0;
			quotient   <= '0;
		end
		else if (load)
		begin
			partRem    <= '0;
			dividendSh <= dividend;
			divisorQ   <= divisor;
			quotient   <= '0;
		end
		else if (step)
		begin
			// Restore by keeping the shifted value when the subtract borrows
			// Either choice is below the divisor again and fits the word
			partRem    <= qBit ? diff[DATA_W-1:0] : shifted[DATA_W-1:0];
			dividendSh <= dividendSh << 1;
			quotient   <= {quotient[DATA_W-2:0], qBit};
		end
	end

	assign remainder = partRem;

endmodule

// File: src/divResultFix.sv
// Divide result fix-up
// Applies the quotient and remainder signs, picks one of them, extends it
// from the operand size and substitutes the divide-by-zero values

`timescale 1ns/10ps

module divResultFix (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      fixLoad,
	input  logic                      negQ,
	input  logic                      negR,
	input  logic                      remSel,
	input  logic                      signedOp,
	input  logic                      zeroDiv,
	input  divPkg::opSize_t           opSize,
	input  logic [divPkg::DATA_W-1:0] quotient,
	input  logic [divPkg::DATA_W-1:0] remainder,
	input  logic [divPkg::DATA_W-1:0] dividendAbs,
	output logic [divPkg::DATA_W-1:0] result
);
	import divPkg::*;

	logic [DATA_W-1:0] quotSigned;
	logic [DATA_W-1:0] remSigned;
	logic [DATA_W-1:0] quotFinal;
	logic [DATA_W-1:0] picked;

	// A signed overflow needs no special case, its magnitude wraps on extension
	assign quotSigned = negQ ? -quotient : quotient;

	// A zero divisor leaves the dividend magnitude in the remainder,
	// which then takes back the dividend's own sign
	assign remSigned = negR ? -remainder : remainder;

	// All ones for the quotient of a zero divide
	assign quotFinal = zeroDiv ? {DATA_W{1'b1}} : quotSigned;

	assign picked = remSel ? remSigned : quotFinal;

	// ==============================
	// Result register
	// ==============================

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			result <= '0;
		else if (fixLoad)
			result <= sizeExtend(picked, opSize, signedOp);
	end

endmodule

// File: src/divUnit.sv
// Integer divide unit
// Takes one divide micro-op per issue, runs a one bit per cycle restoring
// divide and returns the sized result with its destination register

`timescale 1ns/10ps

module divUnit (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      issue,
	input  isaPkg::microOp_t          uop,
	input  logic [divPkg::DATA_W-1:0] opA,
	input  logic [divPkg::DATA_W-1:0] opB,
	output logic                      busy,
	output logic                      done,
	output logic [divPkg::DATA_W-1:0] result,
	output isaPkg::regNum_t           resultRd,
	output logic                      divByZero
);
	import divPkg::*;

	// Decode outputs
	logic              isDiv;
	logic              signedOp;
	logic              remSel;
	opSize_t           opSize;
	logic [DATA_W-1:0] divisorRaw;

	// Sequencing
	logic              accept;
	logic              iterEn;
	logic              fixLoad;
	logic              lastIter;

	// Registered operation attributes
	logic              negQ;
	logic              negR;
	logic              remSelQ;
	logic              signedQ;
	opSize_t           sizeQ;

	// Datapath
	logic [DATA_W-1:0] absDividend;
	logic [DATA_W-1:0] absDivisor;
	logic [DATA_W-1:0] quotient;
	logic [DATA_W-1:0] remainder;

	divDecode u_decode (
		.uop        (uop),
		.opB        (opB),
		.isDiv      (isDiv),
		.signedOp   (signedOp),
		.remSel     (remSel),
		.useImm     (),
		.opSize     (opSize),
		.divisorRaw (divisorRaw)
	);

	divControl u_control (
		.clk      (clk),
		.arstN    (arstN),
		.issue    (issue),
		.isDiv    (isDiv),
		.lastIter (lastIter),
		.accept   (accept),
		.iterEn   (iterEn),
		.fixLoad  (fixLoad),
		.busy     (busy),
		.done     (done)
	);

	divIterCounter u_counter (
		.clk      (clk),
		.arstN    (arstN),
		.load     (accept),
		.countEn  (iterEn),
		.opSize   (opSize),
		.lastIter (lastIter)
	);

	// The rd field sits at the same bits in both formats
	divOperandPrep u_prep (
		.clk         (clk),
		.arstN       (arstN),
		.accept      (accept),
		.signedOp    (signedOp),
		.remSel      (remSel),
		.opSize      (opSize),
		.opA         (opA),
		.divisorRaw  (divisorRaw),
		.rd          (uop.r3.rd),
		.absDividend (absDividend),
		.absDivisor  (absDivisor),
		.negQ        (negQ),
		.negR        (negR),
		.remSelQ     (remSelQ),
		.signedQ     (signedQ),
		.zeroDiv     (divByZero),
		.sizeQ       (sizeQ),
		.rdQ         (resultRd)
	);

	divCore u_core (
		.clk       (clk),
		.arstN     (arstN),
		.load      (accept),
		.step      (iterEn),
		.dividend  (absDividend),
		.divisor   (absDivisor),
		.quotient  (quotient),
		.remainder (remainder)
	);

	// With a zero divisor every trial subtract succeeds, so the partial
	// remainder ends up holding the dividend magnitude at the operand size
	divResultFix u_fix (
		.clk         (clk),
		.arstN       (arstN),
		.fixLoad     (fixLoad),
		.negQ        (negQ),
		.negR        (negR),
		.remSel      (remSelQ),
		.signedOp    (signedQ),
		.zeroDiv     (divByZero),
		.opSize      (sizeQ),
		.quotient    (quotient),
		.remainder   (remainder),
		.dividendAbs (remainder),
		.result      (result)
	);

endmodule

// File: tests/divUnitTb.sv
// Testbench for the integer divide unit
// Drives random and directed divide micro-ops at all sizes, checks every
// result against a software model and watches latency, busy and done

`timescale 1ns/10ps

module divUnitTb;
	import isaPkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_RAND     = 150;
	localparam int NUM_IMM      = 40;
	localparam int NUM_ZERO     = 13;
	localparam int NUM_OVF      = 7;
	localparam int NUM_NONDIV   = 3;
	localparam int NUM_OPS      = NUM_RAND + NUM_IMM + NUM_ZERO + NUM_OVF + NUM_NONDIV;
	localparam int IDLE_WATCH   = 40;

	logic        clk;
	logic        arstN;
	logic        issue;
	microOp_t    uop;
	logic [31:0] opA;
	logic [31:0] opB;
	logic        busy;
	logic        done;
	logic [31:0] result;
	regNum_t     resultRd;
	logic        divByZero;

	logic [31:0] lcgState = 32'h676f64e3;
	int          cycleCount = 0;

	// Expected responses of the divide in flight, oldest first
	logic [31:0] expResult[$];
	regNum_t     expRd[$];
	logic        expZero[$];
	int          expAccept[$];
	int          expIters[$];

	divUnit u_dut (
		.clk       (clk),
		.arstN     (arstN),
		.issue     (issue),
		.uop       (uop),
		.opA       (opA),
		.opB       (opB),
		.busy      (busy),
		.done      (done),
		.result    (result),
		.resultRd  (resultRd),
		.divByZero (divByZero)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Counts rising edges, read only on falling edges
	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		nextRand = lcgState;
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	// Software model of the divide rules, widened so overflow cannot occur
	function automatic logic [31:0] refDiv(
		input  logic [6:0]  opc,
		input  logic [5:0]  fn,
		input  int          bits,
		input  logic [31:0] a,
		input  logic [31:0] divisor,
		output logic        zeroFlag
	);
		longint mask;
		longint x;
		longint y;
		longint v;
		logic   sgn;
		logic   rem;
		mask = (longint'(1) << bits) - 1;
		sgn  = (opc == OP_DIVI) || (fn == FN_DIV) || (fn == FN_MOD);
		rem  = (opc != OP_DIVI) && ((fn == FN_MOD) || (fn == FN_MODU));
		x = {32'b0, a} & mask;
		y = {32'b0, divisor} & mask;
		if (sgn && x[bits-1])
			x = x - (longint'(1) << bits);
		if (sgn && y[bits-1])
			y = y - (longint'(1) << bits);
		zeroFlag = (y == 0);
		// Zero divisor gives all ones and the dividend back
		if (y == 0)
			v = rem ? x : -1;
		else
			v = rem ? (x % y) : (x / y);
		// Truncating to the size makes the signed overflow wrap
		v = v & mask;
		if (sgn && v[bits-1])
			v = v | ~mask;
		refDiv = v[31:0];
	endfunction

	function automatic microOp_t makeR3(input opcode_t opc, input func_t fn);
		microOp_t    op;
		logic [31:0] r;
		r = nextRand();
		op.r3.opcode = opc;
		op.r3.rd     = r[4:0];
		op.r3.rs1    = r[9:5];
		op.r3.rs2    = r[14:10];
		op.r3.func   = fn;
		op.r3.spare  = r[18:15];
		makeR3 = op;
	endfunction

	function automatic microOp_t makeImm(input logic [14:0] imm);
		microOp_t    op;
		logic [31:0] r;
		r = nextRand();
		op.ri.opcode = OP_DIVI;
		op.ri.rd     = r[4:0];
		op.ri.rs1    = r[9:5];
		op.ri.imm    = imm;
		makeImm = op;
	endfunction

	// Called on a falling edge with the divider idle, returns once it is idle again
	task automatic runDivide(
		input microOp_t    op,
		input logic [31:0] a,
		input logic [31:0] b,
		input int          bits,
		input logic [31:0] divisor
	);
		logic [31:0] exp;
		logic        zf;
		exp = refDiv(op.r3.opcode, op.r3.func, bits, a, divisor, zf);
		issue = 1'b1;
		uop   = op;
		opA   = a;
		opB   = b;
		expResult.push_back(exp);
		expRd.push_back(op.r3.rd);
		expZero.push_back(zf);
		expAccept.push_back(cycleCount + 1);
		expIters.push_back(bits);
		@(negedge clk);
		// Junk on the inputs must not disturb a running divide
		issue = 1'b0;
		uop   = nextRand();
		opA   = nextRand();
		opB   = nextRand();
		while (busy)
			@(negedge clk);
		assert (expResult.size() == 0)
		else
			failRun("divider went idle without returning a result");
	endtask

	task automatic runNonDivide(input microOp_t op);
		issue = 1'b1;
		uop   = op;
		opA   = nextRand();
		opB   = nextRand();
		@(negedge clk);
		issue = 1'b0;
		repeat (IDLE_WATCH)
		begin
			assert (!busy && !done)
			else
				failRun("a non-divide micro-op started the divider");
			@(negedge clk);
		end
	endtask

	// ==============================
	// Checker
	// ==============================

	initial
	begin
		forever
		begin
			@(negedge clk);
			if (arstN && expAccept.size() > 0 && cycleCount >= expAccept[0])
			begin
				assert (busy)
				else
					failRun("busy dropped while a divide was in flight");
				if (done)
				begin
					assert (cycleCount == expAccept[0] + expIters[0] + 1)
					else
						failRun($sformatf("done came %0d cycles after accept, expected %0d",
							cycleCount - expAccept[0], expIters[0] + 1));
					assert (result == expResult[0])
					else
						failRun($sformatf("mismatch time=%0t signal=result got=%h expected=%h",
							$time, result, expResult[0]));
					assert (resultRd == expRd[0])
					else
						failRun($sformatf("mismatch time=%0t signal=resultRd got=%0d expected=%0d",
							$time, resultRd, expRd[0]));
					assert (divByZero == expZero[0])
					else
						failRun($sformatf("mismatch time=%0t signal=divByZero got=%b expected=%b",
							$time, divByZero, expZero[0]));
					void'(expResult.pop_front());
					void'(expRd.pop_front());
					void'(expZero.pop_front());
					void'(expAccept.pop_front());
					void'(expIters.pop_front());
				end
			end
			else if (arstN)
			begin
				assert (!done)
				else
					failRun("done pulsed with no divide in flight");
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================

	initial
	begin
		int          i;
		int          bits;
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] mask32;
		logic [14:0] imm;
		opcode_t     opc;
		func_t       fn;
		microOp_t    op;
		arstN = 1'b0;
		issue = 1'b0;
		uop   = '0;
		opA   = '0;
		opB   = '0;
		repeat (RESET_CYCLES)
			@(negedge clk);
		arstN = 1'b1;
		@(negedge clk);
		assert (!busy && !done)
		else
			failRun("busy or done high after reset");
		assert (result == '0)
		else
			failRun($sformatf("mismatch time=%0t signal=result got=%h expected=%h",
				$time, result, 32'h0));

		// Register forms at every size and function
		for (i = 0; i < NUM_RAND; i++)
		begin
			r = nextRand();
			case (r[1:0])
				2'd0:
				begin
					opc  = OP_R3B;
					bits = 8;
				end
				2'd1:
				begin
					opc  = OP_R3W;
					bits = 16;
				end
				default:
				begin
					opc  = OP_R3T;
					bits = 32;
				end
			endcase
			case (r[3:2])
				2'd0:    fn = FN_DIV;
				2'd1:    fn = FN_DIVU;
				2'd2:    fn = FN_MOD;
				default: fn = FN_MODU;
			endcase
			a = nextRand();
			b = nextRand();
			// Small divisors of either sign give long quotients
			if (r[5:4] == 2'd0)
				b = b & 32'h7;
			else if (r[5:4] == 2'd1)
				b = -(b & 32'h7);
			if (r[7:6] == 2'd0)
				a = 32'h1 << (bits - 1);
			runDivide(makeR3(opc, fn), a, b, bits, b);
		end

		// Immediate form, divisor is the sign-extended 15-bit field
		for (i = 0; i < NUM_IMM; i++)
		begin
			r = nextRand();
			imm = r[14:0];
			if (r[16])
				imm = {{10{r[17]}}, r[4:0]};
			runDivide(makeImm(imm), nextRand(), nextRand(), 32, {{17{imm[14]}}, imm});
		end

		// Zero divisor at the size, with junk above it
		for (i = 0; i < NUM_ZERO - 1; i++)
		begin
			bits   = (i / 4 == 0) ? 8 : ((i / 4 == 1) ? 16 : 32);
			opc    = (bits == 8) ? OP_R3B : ((bits == 16) ? OP_R3W : OP_R3T);
			fn     = (i % 4 == 0) ? FN_DIV : ((i % 4 == 1) ? FN_DIVU :
				((i % 4 == 2) ? FN_MOD : FN_MODU));
			mask32 = (bits == 32) ? 32'hFFFFFFFF : ((32'h1 << bits) - 1);
			b      = nextRand() & ~mask32;
			runDivide(makeR3(opc, fn), nextRand(), b, bits, b);
		end
		runDivide(makeImm(15'h0), nextRand(), nextRand(), 32, 32'h0);

		// Most negative value over minus one at each size
		for (i = 0; i < NUM_OVF - 1; i++)
		begin
			bits   = (i / 2 == 0) ? 8 : ((i / 2 == 1) ? 16 : 32);
			opc    = (bits == 8) ? OP_R3B : ((bits == 16) ? OP_R3W : OP_R3T);
			fn     = (i % 2 == 0) ? FN_DIV : FN_MOD;
			mask32 = (bits == 32) ? 32'hFFFFFFFF : ((32'h1 << bits) - 1);
			a      = (nextRand() & ~mask32) | (32'h1 << (bits - 1));
			runDivide(makeR3(opc, fn), a, 32'hFFFFFFFF, bits, 32'hFFFFFFFF);
		end
		runDivide(makeImm(15'h7FFF), 32'h80000000, nextRand(), 32, 32'hFFFFFFFF);

		// Opcodes that are not divides are dropped
		runNonDivide(makeR3(OP_ADD, FN_DIVU));
		runNonDivide(makeR3(OP_R3T, FN_ADD));
		r = nextRand();
		op = makeImm(r[14:0]);
		op.ri.opcode = OP_ORI;
		runNonDivide(op);

		$display("test passed");
		$finish;
	end

	// Budget of 40 cycles per operation on top of reset
	initial
	begin
		#((NUM_OPS * 40 + RESET_CYCLES + 20) * CLK_PERIOD);
		$display("watchdog timeout: the run did not finish in the allowed time");
		$display("test failed");
		$fatal(1);
	end

endmodule

// File: sim.f
src/isaPkg.sv
src/divPkg.sv
src/divDecode.sv
src/divIterCounter.sv
src/divControl.sv
src/divOperandPrep.sv
src/divCore.sv
src/divResultFix.sv
src/divUnit.sv
tests/divUnitTb.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  # Packages come first, then the blocks and the top level
  - files:
      - src/isaPkg.sv
      - src/divPkg.sv
      - src/divDecode.sv
      - src/divIterCounter.sv
      - src/divControl.sv
      - src/divOperandPrep.sv
      - src/divCore.sv
      - src/divResultFix.sv
      - src/divUnit.sv
  - target: test
    files:
      - tests/divUnitTb.sv
